// File: hdl/soc_ctrl_pkg.sv
// Register map of a 4 KB APB slave; N_IO must not exceed 2**PAD_IDX_W or 256 window slots
package soc_ctrl_pkg;

  localparam int ADDR_W      = 12;  // APB address bits
  localparam int N_IO        = 16;  // Pads in the table
  localparam int PAD_IDX_W   = 4;
  localparam int NBIT_PADCFG = 6;
  localparam int NBIT_PADMUX = 2;
  localparam int JTAG_W      = 8;
  localparam int NB_MASTER   = 4;   // Peripheral timeout sources
  localparam int NB_CORES    = 4;
  localparam int NB_CLUSTERS = 0;
  localparam int WD_W        = 31;  // Watchdog counter width
  localparam int RTO_W       = 20;  // Ready timeout counter width

  // Reset and special read values
  localparam logic [31:0]      BOOTADDR_RST  = 32'h1A00_0080;
  localparam logic [RTO_W-1:0] RTO_COUNT_RST = 20'h000FF;
  localparam logic [WD_W-1:0]  WD_COUNT_RST  = 31'd32768;
  localparam logic [15:0]      WD_KICK       = 16'h6699;
  localparam logic [31:0]      PAD_OOR_DATA  = 32'h0095_BEEF;
  localparam logic [31:0]      BAD_READ_DATA = 32'hDEAD_BEEF;

  // Register offsets
  localparam logic [ADDR_W-1:0] OFF_INFO           = 12'h000;
  localparam logic [ADDR_W-1:0] OFF_FCBOOT         = 12'h004;
  localparam logic [ADDR_W-1:0] OFF_FCFETCH        = 12'h008;
  localparam logic [ADDR_W-1:0] OFF_WCFGFUN        = 12'h060;
  localparam logic [ADDR_W-1:0] OFF_RCFGFUN        = 12'h064;
  localparam logic [ADDR_W-1:0] OFF_JTAGREG        = 12'h074;
  localparam logic [ADDR_W-1:0] OFF_WD_COUNT       = 12'h0D0;
  localparam logic [ADDR_W-1:0] OFF_WD_CONTROL     = 12'h0D4;
  localparam logic [ADDR_W-1:0] OFF_RTO_PERIPHERAL = 12'h0E0;
  localparam logic [ADDR_W-1:0] OFF_RTO_COUNT      = 12'h0E4;
  localparam logic [ADDR_W-1:0] OFF_SOFT_RESET     = 12'h0FC;
  localparam logic [ADDR_W-1:0] PAD_WIN_BASE       = 12'h400;  // One word per pad up to 0x7FC

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT
  } apb_state_e;

  typedef enum logic [3:0] {
    REG_INFO,
    REG_FCBOOT,
    REG_FCFETCH,
    REG_WCFGFUN,
    REG_RCFGFUN,
    REG_JTAGREG,
    REG_WD_COUNT,
    REG_WD_CONTROL,
    REG_RTO_PERIPHERAL,
    REG_RTO_COUNT,
    REG_SOFT_RESET,
    REG_PAD_WIN,   // Window slot inside the pad table
    REG_PAD_OOR,   // Window slot beyond N_IO
    REG_NONE
  } reg_e;

endpackage

// File: hdl/soc_ctrl_apb_decode.sv
// Fixed two-edge latency after PENABLE; master must hold PADDR/PWDATA until PREADY is seen
`timescale 1ns/1ps

module soc_ctrl_apb_decode (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic [soc_ctrl_pkg::ADDR_W-1:0]    paddr_i,
  input  logic [31:0]                        pwdata_i,
  input  logic                               pwrite_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  output logic                               pready_o,
  output logic                               pslverr_o,
  output soc_ctrl_pkg::reg_e                 reg_id_o,
  output logic [soc_ctrl_pkg::PAD_IDX_W-1:0] pad_idx_o,
  output logic [31:0]                        wdata_o,
  output logic                               wr_stb_o,
  output logic                               rd_stb_o
);
  import soc_ctrl_pkg::*;

  apb_state_e        state_q;
  logic              access_cyc;
  logic              bad_access;
  logic [ADDR_W-5:0] win_word;

  assign win_word  = paddr_i[ADDR_W-3:2];
  assign pad_idx_o = paddr_i[2 +: PAD_IDX_W];
  assign wdata_o   = pwdata_i;

  // Address to register identifier
  always_comb begin
    reg_id_o = REG_NONE;
    case (paddr_i)
      OFF_INFO:           reg_id_o = REG_INFO;
      OFF_FCBOOT:         reg_id_o = REG_FCBOOT;
      OFF_FCFETCH:        reg_id_o = REG_FCFETCH;
      OFF_WCFGFUN:        reg_id_o = REG_WCFGFUN;
      OFF_RCFGFUN:        reg_id_o = REG_RCFGFUN;
      OFF_JTAGREG:        reg_id_o = REG_JTAGREG;
      OFF_WD_COUNT:       reg_id_o = REG_WD_COUNT;
      OFF_WD_CONTROL:     reg_id_o = REG_WD_CONTROL;
      OFF_RTO_PERIPHERAL: reg_id_o = REG_RTO_PERIPHERAL;
      OFF_RTO_COUNT:      reg_id_o = REG_RTO_COUNT;
      OFF_SOFT_RESET:     reg_id_o = REG_SOFT_RESET;
      default: begin
        if (paddr_i[ADDR_W-1 -: 2] == PAD_WIN_BASE[ADDR_W-1 -: 2]) begin
          reg_id_o = (win_word < N_IO) ? REG_PAD_WIN : REG_PAD_OOR;
        end
      end
    endcase
  end

  // Strobe only in the first ACCESS cycle, before PREADY goes out
  assign access_cyc = (state_q == ACCESS) && !pready_o;
  assign wr_stb_o   = access_cyc && pwrite_i;
  assign rd_stb_o   = access_cyc && !pwrite_i;

  // INFO is read only; a write to RTO_PERIPHERAL clears its flags instead
  assign bad_access = (reg_id_o == REG_NONE) || (pwrite_i && reg_id_o == REG_INFO);

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state_q   <= IDLE;
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (psel_i && penable_i) state_q <= ACCESS;
        end
        ACCESS: begin
          if (!pready_o) begin
            pready_o  <= 1'b1;        // Response with the register update
            pslverr_o <= bad_access;
          end else begin
            pready_o  <= 1'b0;
            pslverr_o <= 1'b0;
            state_q   <= WAIT;        // Let the master drop PENABLE
          end
        end
        WAIT:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Master still holds the access while a strobe acts on it
  a_strobe_held: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (wr_stb_o || rd_stb_o) |-> (psel_i && penable_i));

  a_ready_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pready_o |=> !pready_o);

endmodule

// File: hdl/soc_ctrl_regs.sv
// Pad table indexed by PAD_IDX_W bits; soc_jtag_reg_i is taken as a slow asynchronous mailbox
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  input  soc_ctrl_pkg::reg_e                   reg_id_i,
  input  logic [soc_ctrl_pkg::PAD_IDX_W-1:0]   pad_idx_i,
  input  logic [31:0]                          wdata_i,
  input  logic                                 wr_stb_i,
  input  logic [soc_ctrl_pkg::JTAG_W-1:0]      soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADMUX-1:0] pad_mux_o,
  output logic [soc_ctrl_pkg::JTAG_W-1:0]      soc_jtag_reg_o,
  output logic [soc_ctrl_pkg::JTAG_W-1:0]      jtag_sync_o,
  output logic [31:0]                          fc_bootaddr_o,
  output logic                                 fc_fetchen_o,
  output logic [soc_ctrl_pkg::PAD_IDX_W-1:0]   sel_pad_o,
  output logic                                 soft_reset_o
);
  import soc_ctrl_pkg::*;

  logic [JTAG_W-1:0]    jtag_meta_q;  // First synchronizer stage
  logic [PAD_IDX_W-1:0] wr_pad;

  assign wr_pad = wdata_i[PAD_IDX_W-1:0];  // Pad select field of WCFGFUN and RCFGFUN

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      jtag_meta_q    <= '0;
      jtag_sync_o    <= '0;
      soc_jtag_reg_o <= '0;
      fc_bootaddr_o  <= BOOTADDR_RST;
      fc_fetchen_o   <= 1'b1;   // Core fetches right after reset
      sel_pad_o      <= '0;
      pad_cfg_o      <= '1;
      pad_mux_o      <= '0;
      soft_reset_o   <= 1'b0;
    end else begin
      jtag_meta_q  <= soc_jtag_reg_i;
      jtag_sync_o  <= jtag_meta_q;
      soft_reset_o <= 1'b0;
      if (wr_stb_i) begin
        case (reg_id_i)
          REG_FCBOOT:  fc_bootaddr_o <= wdata_i;
          REG_FCFETCH: fc_fetchen_o  <= wdata_i[0];
          REG_WCFGFUN: begin
            sel_pad_o         <= wr_pad;
            pad_cfg_o[wr_pad] <= wdata_i[24 +: NBIT_PADCFG];
            pad_mux_o[wr_pad] <= wdata_i[16 +: NBIT_PADMUX];
          end
          REG_RCFGFUN: sel_pad_o <= wr_pad;  // Select for a later read only
          REG_JTAGREG: soc_jtag_reg_o <= wdata_i[JTAG_W-1:0];
          REG_PAD_WIN: begin
            sel_pad_o            <= pad_idx_i;
            pad_cfg_o[pad_idx_i] <= wdata_i[8 +: NBIT_PADCFG];
            pad_mux_o[pad_idx_i] <= wdata_i[0 +: NBIT_PADMUX];
          end
          REG_SOFT_RESET: begin
            soft_reset_o <= 1'b1;     // One-cycle pulse
            sel_pad_o    <= '0;
            pad_cfg_o    <= '1;
            pad_mux_o    <= '0;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: hdl/soc_ctrl_watchdog.sv
// ref_clk_i is a tick strobe synchronous to HCLK; once enabled only HRESETn stops the watchdog
`timescale 1ns/1ps

module soc_ctrl_watchdog (
  input  logic                          HCLK,
  input  logic                          HRESETn,
  input  soc_ctrl_pkg::reg_e            reg_id_i,
  input  logic [31:0]                   wdata_i,
  input  logic                          wr_stb_i,
  input  logic                          ref_clk_i,
  input  logic                          stoptimer_i,
  output logic                          wd_expired_o,
  output logic                          wd_enabled_o,
  output logic [soc_ctrl_pkg::WD_W-1:0] wd_count_o
);
  import soc_ctrl_pkg::*;

  logic [WD_W-1:0] wd_cur_q;  // Running count
  logic            tick;

  assign tick = wd_enabled_o && ref_clk_i && !stoptimer_i;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wd_enabled_o <= 1'b0;
      wd_expired_o <= 1'b0;
      wd_count_o   <= WD_COUNT_RST;
      wd_cur_q     <= WD_COUNT_RST;
    end else begin
      if (tick && wd_cur_q != '0) wd_cur_q <= wd_cur_q - 1'b1;
      if (wd_enabled_o && wd_cur_q == '0) wd_expired_o <= 1'b1;  // Sticky
      if (wr_stb_i) begin
        case (reg_id_i)
          REG_WD_COUNT: begin
            if (!wd_enabled_o) wd_count_o <= wdata_i[WD_W-1:0];  // Locked while running
          end
          REG_WD_CONTROL: begin
            if (wdata_i[0] && !wd_enabled_o) begin
              wd_enabled_o <= 1'b1;
              wd_cur_q     <= wd_count_o;
            end
            if (wd_enabled_o && wdata_i[15:0] == WD_KICK) wd_cur_q <= wd_count_o;
          end
          default: ;
        endcase
      end
    end
  end

  // Running count never exceeds the locked reload value
  a_count_bounded: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wd_enabled_o |-> (wd_cur_q <= wd_count_o));

endmodule

// File: hdl/soc_ctrl_rto.sv
// start_rto_i is synchronous to HCLK; the countdown wraps if held past zero
`timescale 1ns/1ps

module soc_ctrl_rto (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  soc_ctrl_pkg::reg_e                 reg_id_i,
  input  logic [31:0]                        wdata_i,
  input  logic                               wr_stb_i,
  input  logic                               start_rto_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0] peripheral_rto_i,
  output logic                               rto_o,
  output logic [soc_ctrl_pkg::RTO_W-1:0]     rto_count_o,
  output logic [soc_ctrl_pkg::NB_MASTER-1:0] periph_rto_o
);
  import soc_ctrl_pkg::*;

  logic [RTO_W-1:0] rto_cnt_q;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rto_cnt_q    <= RTO_COUNT_RST;
      rto_count_o  <= RTO_COUNT_RST;
      periph_rto_o <= '0;
      rto_o        <= 1'b0;
    end else begin
      rto_cnt_q    <= start_rto_i ? rto_cnt_q - 1'b1 : rto_count_o;  // Reload when idle
      rto_o        <= (rto_cnt_q == '0);
      periph_rto_o <= periph_rto_o | peripheral_rto_i;
      if (wr_stb_i) begin
        case (reg_id_i)
          REG_RTO_COUNT:      rto_count_o  <= {wdata_i[RTO_W-1:4], 4'hF};
          REG_RTO_PERIPHERAL: periph_rto_o <= '0;  // Write of any value clears
          REG_SOFT_RESET: begin
            rto_count_o  <= RTO_COUNT_RST;
            periph_rto_o <= '0;
          end
          default: ;
        endcase
      end
    end
  end

endmodule

// File: hdl/soc_ctrl_rdata.sv
// PRDATA holds its value between reads; window reads never change the selected pad
`timescale 1ns/1ps

module soc_ctrl_rdata (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  soc_ctrl_pkg::reg_e                 reg_id_i,
  input  logic                               rd_stb_i,
  input  logic [soc_ctrl_pkg::PAD_IDX_W-1:0] pad_idx_i,
  input  logic [31:0]                        bootaddr_i,
  input  logic                               fetchen_i,
  input  logic [soc_ctrl_pkg::JTAG_W-1:0]    jtag_out_i,
  input  logic [soc_ctrl_pkg::JTAG_W-1:0]    jtag_in_sync_i,
  input  logic [soc_ctrl_pkg::PAD_IDX_W-1:0] sel_pad_i,
  input  logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADCFG-1:0] pad_cfg_i,
  input  logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADMUX-1:0] pad_mux_i,
  input  logic                               wd_enabled_i,
  input  logic [soc_ctrl_pkg::WD_W-1:0]      wd_count_i,
  input  logic [soc_ctrl_pkg::RTO_W-1:0]     rto_count_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0] periph_rto_i,
  output logic [31:0]                        prdata_o
);
  import soc_ctrl_pkg::*;

  logic [NBIT_PADCFG-1:0] sel_cfg;
  logic [NBIT_PADMUX-1:0] sel_mux;
  logic [NBIT_PADCFG-1:0] win_cfg;
  logic [NBIT_PADMUX-1:0] win_mux;
  logic [31:0]            rd_data;

  assign sel_cfg = pad_cfg_i[sel_pad_i];
  assign sel_mux = pad_mux_i[sel_pad_i];
  assign win_cfg = pad_cfg_i[pad_idx_i];
  assign win_mux = pad_mux_i[pad_idx_i];

  always_comb begin
    rd_data = '0;
    case (reg_id_i)
      REG_INFO:    rd_data = {16'(NB_CORES), 16'(NB_CLUSTERS)};
      REG_FCBOOT:  rd_data = bootaddr_i;
      REG_FCFETCH: rd_data = {31'b0, fetchen_i};
      REG_WCFGFUN, REG_RCFGFUN: begin
        rd_data[0 +: PAD_IDX_W]    = sel_pad_i;
        rd_data[16 +: NBIT_PADMUX] = sel_mux;
        rd_data[24 +: NBIT_PADCFG] = sel_cfg;
      end
      REG_JTAGREG:        rd_data = {16'h0, jtag_in_sync_i, jtag_out_i};
      REG_WD_COUNT:       rd_data = {1'b0, wd_count_i};
      REG_WD_CONTROL:     rd_data = {wd_enabled_i, wd_count_i};  // Enable above reload
      REG_RTO_PERIPHERAL: rd_data = {{(32-NB_MASTER){1'b0}}, periph_rto_i};
      REG_RTO_COUNT:      rd_data = {{(32-RTO_W){1'b0}}, rto_count_i};
      REG_PAD_WIN: begin
        rd_data[8 +: NBIT_PADCFG] = win_cfg;
        rd_data[0 +: NBIT_PADMUX] = win_mux;
      end
      REG_PAD_OOR: rd_data = PAD_OOR_DATA;
      REG_NONE:    rd_data = BAD_READ_DATA;
      default:     rd_data = '0;   // SOFT_RESET reads as zero
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      prdata_o <= '0;
    end else if (rd_stb_i) begin
      prdata_o <= rd_data;
    end
  end

endmodule

// File: hdl/apb_soc_ctrl.sv
// APB slave with a fixed register map; eFPGA, build info and reset reason registers are absent
`timescale 1ns/1ps

module apb_soc_ctrl (
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic [soc_ctrl_pkg::ADDR_W-1:0]    paddr_i,
  input  logic [31:0]                        pwdata_i,
  input  logic                               pwrite_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  output logic [31:0]                        prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  input  logic                               ref_clk_i,
  input  logic                               stoptimer_i,
  output logic                               wd_expired_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADCFG-1:0] pad_cfg_o,
  output logic [soc_ctrl_pkg::N_IO-1:0][soc_ctrl_pkg::NBIT_PADMUX-1:0] pad_mux_o,
  input  logic [soc_ctrl_pkg::JTAG_W-1:0]    soc_jtag_reg_i,
  output logic [soc_ctrl_pkg::JTAG_W-1:0]    soc_jtag_reg_o,
  output logic [31:0]                        fc_bootaddr_o,
  output logic                               fc_fetchen_o,
  output logic                               rto_o,
  input  logic                               start_rto_i,
  input  logic [soc_ctrl_pkg::NB_MASTER-1:0] peripheral_rto_i,
  output logic                               soft_reset_o
);
  import soc_ctrl_pkg::*;

  reg_e                 reg_id;
  logic [PAD_IDX_W-1:0] pad_idx;
  logic [31:0]          wdata;
  logic                 wr_stb;
  logic                 rd_stb;
  logic [JTAG_W-1:0]    jtag_in_sync;
  logic [PAD_IDX_W-1:0] sel_pad;
  logic                 wd_enabled;
  logic [WD_W-1:0]      wd_count;
  logic [RTO_W-1:0]     rto_count;
  logic [NB_MASTER-1:0] periph_rto;

  soc_ctrl_apb_decode i_decode (
    .HCLK, .HRESETn, .paddr_i, .pwdata_i, .pwrite_i, .psel_i, .penable_i,
    .pready_o, .pslverr_o,
    .reg_id_o (reg_id), .pad_idx_o (pad_idx), .wdata_o (wdata),
    .wr_stb_o (wr_stb), .rd_stb_o  (rd_stb)
  );

  soc_ctrl_regs i_regs (
    .HCLK, .HRESETn,
    .reg_id_i (reg_id), .pad_idx_i (pad_idx), .wdata_i (wdata), .wr_stb_i (wr_stb),
    .soc_jtag_reg_i, .pad_cfg_o, .pad_mux_o, .soc_jtag_reg_o,
    .jtag_sync_o (jtag_in_sync), .fc_bootaddr_o, .fc_fetchen_o,
    .sel_pad_o (sel_pad), .soft_reset_o
  );

  soc_ctrl_watchdog i_watchdog (
    .HCLK, .HRESETn,
    .reg_id_i (reg_id), .wdata_i (wdata), .wr_stb_i (wr_stb),
    .ref_clk_i, .stoptimer_i, .wd_expired_o,
    .wd_enabled_o (wd_enabled), .wd_count_o (wd_count)
  );

  soc_ctrl_rto i_rto (
    .HCLK, .HRESETn,
    .reg_id_i (reg_id), .wdata_i (wdata), .wr_stb_i (wr_stb),
    .start_rto_i, .peripheral_rto_i, .rto_o,
    .rto_count_o (rto_count), .periph_rto_o (periph_rto)
  );

  soc_ctrl_rdata i_rdata (
    .HCLK, .HRESETn,
    .reg_id_i (reg_id), .rd_stb_i (rd_stb), .pad_idx_i (pad_idx),
    .bootaddr_i (fc_bootaddr_o), .fetchen_i (fc_fetchen_o),
    .jtag_out_i (soc_jtag_reg_o), .jtag_in_sync_i (jtag_in_sync),
    .sel_pad_i (sel_pad), .pad_cfg_i (pad_cfg_o), .pad_mux_i (pad_mux_o),
    .wd_enabled_i (wd_enabled), .wd_count_i (wd_count),
    .rto_count_i (rto_count), .periph_rto_i (periph_rto),
    .prdata_o
  );

endmodule

// File: tb/tb_apb_soc_ctrl.sv
// One APB access at a time; inputs move 2 ns after HCLK rises and ref_clk_i is a per-cycle tick
`timescale 1ns/1ps

module tb_apb_soc_ctrl;
  import soc_ctrl_pkg::*;

  localparam int MAX_CYCLES = 3000;  // About four times the ~700 cycles of the full sequence

  logic HCLK, HRESETn;
  logic [ADDR_W-1:0] paddr;
  logic [31:0] pwdata, prdata;
  logic pwrite, psel, penable, pready, pslverr;
  logic ref_clk, stoptimer, wd_expired, fc_fetchen, rto, start_rto, soft_reset;
  logic [N_IO-1:0][NBIT_PADCFG-1:0] pad_cfg;
  logic [N_IO-1:0][NBIT_PADMUX-1:0] pad_mux;
  logic [JTAG_W-1:0] jtag_in, jtag_out;
  logic [31:0] fc_bootaddr;
  logic [NB_MASTER-1:0] periph_in;
  int cycles;
  string test_name;

  // Register model
  logic [31:0] m_boot;
  logic m_fetch, m_wd_en;
  logic [JTAG_W-1:0] m_jtag_out;
  logic [JTAG_W-1:0] m_jtag_in;
  logic [PAD_IDX_W-1:0] m_sel;
  logic [NBIT_PADCFG-1:0] m_cfg [N_IO];
  logic [NBIT_PADMUX-1:0] m_mux [N_IO];
  logic [30:0] m_wd_count;
  logic [19:0] m_rto;
  logic [NB_MASTER-1:0] m_periph;

  apb_soc_ctrl i_dut (
    .HCLK, .HRESETn, .paddr_i (paddr), .pwdata_i (pwdata), .pwrite_i (pwrite),
    .psel_i (psel), .penable_i (penable), .prdata_o (prdata), .pready_o (pready),
    .pslverr_o (pslverr), .ref_clk_i (ref_clk), .stoptimer_i (stoptimer),
    .wd_expired_o (wd_expired), .pad_cfg_o (pad_cfg), .pad_mux_o (pad_mux),
    .soc_jtag_reg_i (jtag_in), .soc_jtag_reg_o (jtag_out), .fc_bootaddr_o (fc_bootaddr),
    .fc_fetchen_o (fc_fetchen), .rto_o (rto), .start_rto_i (start_rto),
    .peripheral_rto_i (periph_in), .soft_reset_o (soft_reset)
  );

  initial begin
    HCLK = 1'b0;
    forever #10 HCLK = ~HCLK;
  end

  always @(posedge HCLK) cycles <= cycles + 1;

  initial begin
    wait (cycles == MAX_CYCLES);
    $display("Timeout: no end of test after %0d cycles", cycles);
    $display("Regression failed");
    $fatal(1, "Simulation hung");
  end

  task automatic check(input string label, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("FAIL %s %s: expected %h, actual %h", test_name, label, exp, act);
      $display("Regression failed");
      $fatal(1, "Value mismatch in %s", label);
    end
  endtask

  task automatic model_pad_defaults();
    for (int i = 0; i < N_IO; i++) begin
      m_cfg[i] = '1;
      m_mux[i] = '0;
    end
    m_sel = '0;
  endtask

  // Read value and error response that the register map predicts
  function automatic logic [31:0] expected_read(input logic [ADDR_W-1:0] addr,
                                                output logic slverr);
    logic [31:0] rd;
    int idx;
    rd = '0;
    slverr = 1'b0;
    if (addr >= PAD_WIN_BASE && addr < 12'h800) begin
      idx = int'(addr - PAD_WIN_BASE) / 4;
      if (idx < N_IO) begin
        rd[13:8] = m_cfg[idx];
        rd[1:0] = m_mux[idx];
      end else begin
        rd = PAD_OOR_DATA;
      end
    end else begin
      case (addr)
        OFF_INFO: rd = {16'(NB_CORES), 16'(NB_CLUSTERS)};
        OFF_FCBOOT: rd = m_boot;
        OFF_FCFETCH: rd = {31'b0, m_fetch};
        OFF_WCFGFUN, OFF_RCFGFUN: begin
          rd[3:0] = m_sel;
          rd[17:16] = m_mux[m_sel];
          rd[29:24] = m_cfg[m_sel];
        end
        OFF_JTAGREG: rd = {16'h0, m_jtag_in, m_jtag_out};
        OFF_WD_COUNT: rd = {1'b0, m_wd_count};
        OFF_WD_CONTROL: rd = {m_wd_en, m_wd_count};
        OFF_RTO_PERIPHERAL: rd = 32'(m_periph);
        OFF_RTO_COUNT: rd = 32'(m_rto);
        OFF_SOFT_RESET: rd = '0;
        default: begin
          rd = BAD_READ_DATA;
          slverr = 1'b1;
        end
      endcase
    end
    return rd;
  endfunction

  task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    int idx;
    if (addr >= PAD_WIN_BASE && addr < 12'h800) begin
      idx = int'(addr - PAD_WIN_BASE) / 4;
      if (idx < N_IO) begin
        m_cfg[idx] = data[13:8];
        m_mux[idx] = data[1:0];
        m_sel = idx[PAD_IDX_W-1:0];
      end
    end else begin
      case (addr)
        OFF_FCBOOT: m_boot = data;
        OFF_FCFETCH: m_fetch = data[0];
        OFF_WCFGFUN: begin
          m_sel = data[3:0];
          m_cfg[m_sel] = data[29:24];
          m_mux[m_sel] = data[17:16];
        end
        OFF_RCFGFUN: m_sel = data[3:0];
        OFF_JTAGREG: m_jtag_out = data[JTAG_W-1:0];
        OFF_WD_COUNT: if (!m_wd_en) m_wd_count = data[30:0];
        OFF_WD_CONTROL: if (data[0]) m_wd_en = 1'b1;
        OFF_RTO_PERIPHERAL: m_periph = '0;
        OFF_RTO_COUNT: m_rto = {data[19:4], 4'hF};
        OFF_SOFT_RESET: begin
          model_pad_defaults();
          m_rto = RTO_COUNT_RST;
          m_periph = '0;
        end
        default: ;
      endcase
    end
  endtask

  // Setup phase, access phase, then hold until PREADY
  task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic write, output logic [31:0] rdata, output logic err);
    @(posedge HCLK); #2;
    paddr = addr;
    pwdata = data;
    pwrite = write;
    psel = 1'b1;
    penable = 1'b0;
    @(posedge HCLK); #2;
    penable = 1'b1;
    @(posedge HCLK); #2;
    while (!pready) begin
      @(posedge HCLK); #2;
    end
    rdata = prdata;
    err = pslverr;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic err, exp_err;
    rdata = expected_read(addr, exp_err);
    exp_err = exp_err || (addr == OFF_INFO);  // INFO is read only
    apb_access(addr, data, 1'b1, rdata, err);
    check($sformatf("write %h pslverr", addr), 32'(exp_err), 32'(err));
    model_write(addr, data);
  endtask

  task automatic read_check(input string label, input logic [ADDR_W-1:0] addr);
    logic [31:0] exp_data, rdata;
    logic exp_err, err;
    exp_data = expected_read(addr, exp_err);
    apb_access(addr, 32'h0, 1'b0, rdata, err);
    check({label, " data"}, exp_data, rdata);
    check({label, " pslverr"}, 32'(exp_err), 32'(err));
  endtask

  task automatic check_pads();
    for (int i = 0; i < N_IO; i++) begin
      check($sformatf("pad %0d cfg", i), 32'(m_cfg[i]), 32'(pad_cfg[i]));
      check($sformatf("pad %0d mux", i), 32'(m_mux[i]), 32'(pad_mux[i]));
    end
  endtask

  initial begin
    logic [PAD_IDX_W-1:0] pad;
    logic [NBIT_PADCFG-1:0] cfg;
    logic [NBIT_PADMUX-1:0] mux;
    int lim;
    cycles = 0;
    void'($urandom(25));
    {paddr, pwdata, pwrite, psel, penable} = '0;
    {ref_clk, stoptimer, start_rto, periph_in, jtag_in} = '0;
    m_boot = BOOTADDR_RST;
    m_fetch = 1'b1;
    m_wd_en = 1'b0;
    m_wd_count = WD_COUNT_RST;
    m_rto = RTO_COUNT_RST;
    {m_jtag_out, m_jtag_in, m_periph} = '0;
    model_pad_defaults();
    HRESETn = 1'b0;
    repeat (2) @(posedge HCLK);
    #2 HRESETn = 1'b1;

    test_name = "reset";
    check_pads();
    read_check("info", OFF_INFO);
    read_check("fcboot", OFF_FCBOOT);
    read_check("fcfetch", OFF_FCFETCH);
    read_check("rto count", OFF_RTO_COUNT);

    test_name = "pads";
    for (int n = 0; n < 24; n++) begin
      pad = PAD_IDX_W'($urandom % N_IO);
      cfg = NBIT_PADCFG'($urandom);
      mux = NBIT_PADMUX'($urandom);
      if ($urandom % 2 == 0) apb_write(OFF_WCFGFUN, {2'b0, cfg, 6'b0, mux, 12'b0, pad});
      else apb_write(PAD_WIN_BASE + {6'b0, pad, 2'b00}, {18'b0, cfg, 6'b0, mux});
      check_pads();
    end
    for (int p = 0; p < N_IO; p++) begin
      apb_write(OFF_RCFGFUN, 32'(p));
      read_check("rcfgfun", OFF_RCFGFUN);
      read_check("window", PAD_WIN_BASE + 12'(p * 4));
    end
    read_check("wcfgfun", OFF_WCFGFUN);
    read_check("window oor", PAD_WIN_BASE + 12'(N_IO * 4));
    read_check("unmapped", 12'h0C0);
    apb_write(OFF_INFO, 32'h1234_5678);  // Error response expected

    test_name = "jtag boot";
    apb_write(OFF_JTAGREG, 32'h0000_00A5);
    check("jtag pins", 32'(m_jtag_out), 32'(jtag_out));
    apb_write(OFF_FCBOOT, $urandom);
    check("boot pins", m_boot, fc_bootaddr);
    apb_write(OFF_FCFETCH, 32'h0);
    check("fetch pin", 32'(m_fetch), 32'(fc_fetchen));
    jtag_in = 8'h3C;
    m_jtag_in = 8'h3C;
    repeat (4) @(posedge HCLK);
    read_check("jtagreg", OFF_JTAGREG);

    test_name = "watchdog";
    ref_clk = 1'b1;
    apb_write(OFF_WD_COUNT, 32'd20);
    apb_write(OFF_WD_CONTROL, 32'h1);
    for (int k = 0; k < 5; k++) begin
      repeat (6) @(posedge HCLK);
      #2 apb_write(OFF_WD_CONTROL, 32'(WD_KICK));  // Reload every 10 cycles
      check("expired while kicked", 32'h0, 32'(wd_expired));
    end
    for (int w = 0; w < 25 && !wd_expired; w++) begin
      @(posedge HCLK); #2;
    end
    check("expired after kicks stop", 32'h1, 32'(wd_expired));
    repeat (5) @(posedge HCLK);
    #2 check("expired sticky", 32'h1, 32'(wd_expired));
    apb_write(OFF_WD_COUNT, 32'd100);  // Locked while enabled
    read_check("wd count", OFF_WD_COUNT);
    read_check("wd control", OFF_WD_CONTROL);

    test_name = "timeout";
    apb_write(OFF_RTO_COUNT, 32'h0000_0023);
    read_check("rto count", OFF_RTO_COUNT);
    start_rto = 1'b1;
    lim = int'(m_rto) + 3;
    for (int c = 0; c < lim && !rto; c++) begin
      @(posedge HCLK); #2;
    end
    check("rto pulse", 32'h1, 32'(rto));
    start_rto = 1'b0;
    periph_in = 4'b0101;
    @(posedge HCLK); #2 periph_in = 4'b1000;
    @(posedge HCLK); #2 periph_in = '0;
    m_periph = 4'b1101;
    read_check("periph flags", OFF_RTO_PERIPHERAL);
    apb_write(OFF_RTO_PERIPHERAL, 32'h0);
    read_check("periph cleared", OFF_RTO_PERIPHERAL);
    periph_in = 4'b0010;
    @(posedge HCLK); #2 periph_in = '0;
    m_periph = 4'b0010;
    read_check("periph set again", OFF_RTO_PERIPHERAL);

    test_name = "soft reset";
    apb_write(OFF_SOFT_RESET, 32'h1);
    check("pulse high", 32'h1, 32'(soft_reset));
    @(posedge HCLK); #2 check("pulse low", 32'h0, 32'(soft_reset));
    check_pads();
    read_check("rto count", OFF_RTO_COUNT);
    read_check("periph flags", OFF_RTO_PERIPHERAL);
    read_check("rcfgfun", OFF_RCFGFUN);

    $display("Regression passed");
    $finish;
  end

endmodule

// File: apb_soc_ctrl.f
hdl/soc_ctrl_pkg.sv
hdl/soc_ctrl_apb_decode.sv
hdl/soc_ctrl_regs.sv
hdl/soc_ctrl_watchdog.sv
hdl/soc_ctrl_rto.sv
hdl/soc_ctrl_rdata.sv
hdl/apb_soc_ctrl.sv
tb/tb_apb_soc_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; a $fatal gives a failing exit status
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_apb_soc_ctrl \
  -f apb_soc_ctrl.f \
  --Mdir obj_dir

./obj_dir/Vtb_apb_soc_ctrl
